// ==== flist.f ====
hdl/mips_pkg.sv
hdl/wb_issue_port.sv
hdl/main_decode.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/reg_file.sv
hdl/mips_core_top.sv
testbench/tb_mips_core.sv

// ==== testbench/tb_mips_core.sv ====
`timescale 1ns/1ps

module tb_mips_core;

    logic                 clk;
    logic                 rst_n;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    mips_pkg::creg_addr_t wb_adr;
    mips_pkg::word_t      wb_wdata;
    mips_pkg::word_t      wb_rdata;
    logic                 wb_ack;
    logic [7:0]           exc_count;

    logic            tbl_is_check [$];  // Set for a register read and clear for an instruction issue.
    mips_pkg::word_t tbl_data [$];
    mips_pkg::word_t tbl_exp [$];
    mips_pkg::word_t mdl [32];         // Architectural register state seen by the table.
    mips_pkg::word_t lcg_state = 32'd70;
    mips_pkg::word_t rdata;
    int exc_exp = 0;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int cycle_limit = 1000000;

    mips_core_top u_dut (
        .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_rdata, .wb_ack,
        .exc_count
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic mips_pkg::word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic mips_pkg::word_t r_format(input logic [5:0] fn, input logic [4:0] rs,
                                                 input logic [4:0] rt, input logic [4:0] rd,
                                                 input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic mips_pkg::word_t i_format(input logic [5:0] op, input logic [4:0] rs,
                                                 input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Instruction-set semantics of the kept subset, applied to the model registers.
    function automatic void apply_isa(input mips_pkg::word_t instr);
        logic [5:0]      op;
        logic [5:0]      fn;
        logic [4:0]      rs;
        logic [4:0]      rt;
        logic [4:0]      dst;
        logic [4:0]      sh;
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        mips_pkg::word_t se;
        mips_pkg::word_t ze;
        mips_pkg::word_t res;
        logic [32:0]     wide;
        logic            wr;
        logic            ovf;
        op  = instr[31:26];
        fn  = instr[5:0];
        rs  = instr[25:21];
        rt  = instr[20:16];
        sh  = instr[10:6];
        a   = mdl[rs];
        b   = mdl[rt];
        se  = {{16{instr[15]}}, instr[15:0]};
        ze  = {16'h0000, instr[15:0]};
        wr  = 1'b1;
        ovf = 1'b0;
        res = '0;
        dst = rt;
        wide = '0;
        if (op == 6'h00) begin
            dst = instr[15:11];
            case (fn)
                mips_pkg::F_ADD: begin
                    wide = {a[31], a} + {b[31], b};
                    res  = wide[31:0];
                    ovf  = wide[32] != wide[31];
                end
                mips_pkg::F_ADDU: res = a + b;
                mips_pkg::F_SUB: begin
                    wide = {a[31], a} - {b[31], b};
                    res  = wide[31:0];
                    ovf  = wide[32] != wide[31];
                end
                mips_pkg::F_SUBU: res = a - b;
                mips_pkg::F_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                mips_pkg::F_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                mips_pkg::F_AND:  res = a & b;
                mips_pkg::F_OR:   res = a | b;
                mips_pkg::F_XOR:  res = a ^ b;
                mips_pkg::F_NOR:  res = ~(a | b);
                mips_pkg::F_SLL:  res = b << sh;
                mips_pkg::F_SRL:  res = b >> sh;
                mips_pkg::F_SRA:  res = $signed(b) >>> sh;
                mips_pkg::F_SLLV: res = b << a[4:0];
                mips_pkg::F_SRLV: res = b >> a[4:0];
                mips_pkg::F_SRAV: res = $signed(b) >>> a[4:0];
                mips_pkg::F_MOVZ: begin
                    res = a;
                    wr  = (b == '0);
                end
                mips_pkg::F_MOVN: begin
                    res = a;
                    wr  = (b != '0);
                end
                mips_pkg::F_SYNC: wr = 1'b0;
                default: begin
                    wr = 1'b0;
                    exc_exp++;
                end
            endcase
        end else begin
            case (op)
                mips_pkg::OP_ADDI: begin
                    wide = {a[31], a} + {se[31], se};
                    res  = wide[31:0];
                    ovf  = wide[32] != wide[31];
                end
                mips_pkg::OP_ADDIU: res = a + se;
                mips_pkg::OP_SLTI:  res = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
                mips_pkg::OP_SLTIU: res = (a < se) ? 32'd1 : 32'd0;
                mips_pkg::OP_ANDI:  res = a & ze;
                mips_pkg::OP_ORI:   res = a | ze;
                mips_pkg::OP_XORI:  res = a ^ ze;
                mips_pkg::OP_LUI:   res = {instr[15:0], 16'h0000};
                default: begin
                    wr = 1'b0;
                    exc_exp++;
                end
            endcase
        end
        if (ovf) begin
            wr = 1'b0;  // Overflow traps and leaves the destination alone.
            exc_exp++;
        end
        if (wr && dst != 5'd0) mdl[dst] = res;
    endfunction

    function automatic void push_instr(input mips_pkg::word_t instr);
        tbl_is_check.push_back(1'b0);
        tbl_data.push_back(instr);
        tbl_exp.push_back('0);
        apply_isa(instr);
    endfunction

    function automatic void check_reg(input logic [4:0] r);
        tbl_is_check.push_back(1'b1);
        tbl_data.push_back({27'd0, r});
        tbl_exp.push_back(mdl[r]);
    endfunction

    function automatic void run_checked(input mips_pkg::word_t instr, input logic [4:0] r);
        push_instr(instr);
        check_reg(r);
    endfunction

    function automatic void build_table();
        mips_pkg::word_t v;
        for (int r = 0; r < 32; r++) mdl[r] = '0;
        for (int r = 0; r < 32; r++) check_reg(r);
        for (int r = 1; r <= 8; r++) begin
            v = lcg_next();
            push_instr(i_format(mips_pkg::OP_LUI, 0, r, v[31:16]));
            run_checked(i_format(mips_pkg::OP_ORI, r, r, v[15:0]), r);
        end
        push_instr(i_format(mips_pkg::OP_ADDIU, 1, 0, 16'h1234));
        run_checked(i_format(mips_pkg::OP_LUI, 0, 0, 16'hbeef), 0);
        run_checked(r_format(mips_pkg::F_ADD, 1, 2, 10, 0), 10);
        run_checked(r_format(mips_pkg::F_ADDU, 3, 4, 11, 0), 11);
        run_checked(r_format(mips_pkg::F_SUB, 5, 6, 12, 0), 12);
        run_checked(r_format(mips_pkg::F_SUBU, 7, 8, 13, 0), 13);
        run_checked(r_format(mips_pkg::F_SLT, 1, 5, 14, 0), 14);
        run_checked(r_format(mips_pkg::F_SLTU, 2, 6, 15, 0), 15);
        run_checked(r_format(mips_pkg::F_AND, 3, 7, 16, 0), 16);
        run_checked(r_format(mips_pkg::F_OR, 4, 8, 17, 0), 17);
        run_checked(r_format(mips_pkg::F_XOR, 1, 8, 18, 0), 18);
        run_checked(r_format(mips_pkg::F_NOR, 2, 7, 19, 0), 19);
        v = lcg_next() | 32'h8000_8000;  // Bit 15 set so sign and zero extension differ.
        run_checked(i_format(mips_pkg::OP_ADDI, 1, 10, v[15:0]), 10);
        run_checked(i_format(mips_pkg::OP_ADDIU, 2, 11, v[31:16]), 11);
        run_checked(i_format(mips_pkg::OP_SLTI, 3, 12, v[15:0]), 12);
        run_checked(i_format(mips_pkg::OP_SLTIU, 4, 13, v[31:16]), 13);
        run_checked(i_format(mips_pkg::OP_ANDI, 5, 14, v[15:0]), 14);
        run_checked(i_format(mips_pkg::OP_ORI, 6, 15, v[31:16]), 15);
        run_checked(i_format(mips_pkg::OP_XORI, 7, 16, v[15:0]), 16);
        run_checked(i_format(mips_pkg::OP_SLTI, 0, 17, 16'h0004), 17);
        v = lcg_next() | 32'h8000_0000;
        push_instr(i_format(mips_pkg::OP_LUI, 0, 9, v[31:16]));
        run_checked(i_format(mips_pkg::OP_ORI, 9, 9, v[15:0]), 9);
        run_checked(r_format(mips_pkg::F_SLL, 0, 9, 13, 4), 13);
        run_checked(r_format(mips_pkg::F_SRL, 0, 9, 14, 7), 14);
        run_checked(r_format(mips_pkg::F_SRA, 0, 9, 15, 13), 15);
        run_checked(r_format(mips_pkg::F_SLLV, 1, 9, 16, 0), 16);
        run_checked(r_format(mips_pkg::F_SRLV, 2, 9, 17, 0), 17);
        run_checked(r_format(mips_pkg::F_SRAV, 3, 9, 18, 0), 18);
        push_instr(r_format(mips_pkg::F_ADDU, 1, 2, 20, 0));  // Dependent chain issued without gaps.
        push_instr(r_format(mips_pkg::F_SUBU, 20, 3, 21, 0));
        push_instr(r_format(mips_pkg::F_XOR, 21, 20, 22, 0));
        push_instr(r_format(mips_pkg::F_SLL, 0, 22, 23, 3));
        push_instr(i_format(mips_pkg::OP_ADDIU, 23, 20, 16'h7fff));
        push_instr(r_format(mips_pkg::F_OR, 20, 21, 24, 0));
        for (int r = 20; r <= 24; r++) check_reg(r);
        push_instr(i_format(mips_pkg::OP_LUI, 0, 25, 16'h7fff));
        push_instr(i_format(mips_pkg::OP_ORI, 25, 25, 16'hffff));
        push_instr(i_format(mips_pkg::OP_LUI, 0, 26, 16'h8000));
        push_instr(i_format(mips_pkg::OP_ORI, 0, 27, 16'h0001));
        push_instr(i_format(mips_pkg::OP_ORI, 0, 28, 16'h5a5a));
        push_instr(i_format(mips_pkg::OP_ORI, 0, 31, 16'h3131));
        run_checked(r_format(mips_pkg::F_ADD, 25, 25, 28, 0), 28);
        run_checked(i_format(mips_pkg::OP_ADDI, 25, 28, 16'h0001), 28);
        run_checked(r_format(mips_pkg::F_SUB, 26, 27, 28, 0), 28);
        run_checked(r_format(mips_pkg::F_ADDU, 25, 25, 29, 0), 29);
        run_checked(r_format(mips_pkg::F_ADD, 25, 26, 29, 0), 29);
        run_checked(r_format(mips_pkg::F_MOVZ, 1, 0, 28, 0), 28);
        run_checked(r_format(mips_pkg::F_MOVZ, 2, 27, 29, 0), 29);
        run_checked(r_format(mips_pkg::F_MOVN, 3, 27, 30, 0), 30);
        run_checked(r_format(mips_pkg::F_MOVN, 4, 0, 31, 0), 31);
        push_instr(i_format(6'h3f, 1, 12, 16'h1234));  // Unused opcode.
        push_instr(r_format(6'h3f, 1, 2, 12, 0));
        push_instr(r_format(6'h18, 1, 2, 12, 0));  // MULT is dropped.
        push_instr(i_format(6'h23, 1, 12, 16'h0000));
        push_instr(r_format(mips_pkg::F_SYNC, 0, 0, 0, 0));
        push_instr(32'h0000_0000);
        check_reg(12);
        check_reg(0);
    endfunction

    task automatic write_instr(input mips_pkg::word_t instr);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = '0;
        wb_wdata = instr;
        do begin
            @(posedge clk);
            #2;
        end while (!wb_ack);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);
        #2;
    endtask

    task automatic read_reg(input logic [4:0] r, output mips_pkg::word_t data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = r;
        do begin
            @(posedge clk);
            #2;
        end while (!wb_ack);
        data   = wb_rdata;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        @(posedge clk);
        #2;
    endtask

    initial begin
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_wdata = '0;
        build_table();
        cycle_limit = 30 * tbl_data.size() + 100;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int i = 0; i < tbl_data.size(); i++) begin
            if (!tbl_is_check[i]) begin
                write_instr(tbl_data[i]);
            end else begin
                read_reg(tbl_data[i][4:0], rdata);
                checks++;
                assert (rdata === tbl_exp[i]) else begin
                    errors++;
                    $display("Mismatch wb_rdata (r%0d): expected %h, got %h",
                             tbl_data[i][4:0], tbl_exp[i], rdata);
                end
            end
        end
        checks++;
        assert (exc_count === exc_exp[7:0]) else begin
            errors++;
            $display("Mismatch exc_count: expected %h, got %h", exc_exp[7:0], exc_count);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== hdl/mips_core_top.sv ====
`timescale 1ns/1ps

module mips_core_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  mips_pkg::creg_addr_t wb_adr,
    input  mips_pkg::word_t      wb_wdata,
    output mips_pkg::word_t      wb_rdata,
    output logic                 wb_ack,
    output logic [7:0]           exc_count
);
    logic                 issue_valid, busy;
    mips_pkg::word_t      issue_instr, rd_a, rd_b, rd_bus;
    mips_pkg::creg_addr_t rd_addr_a, rd_addr_b, rd_addr_bus;
    logic                 dec_valid, dec_regwrite, dec_movz, dec_movn, dec_trap_ovf, dec_ri;
    mips_pkg::alu_func_t  dec_func;
    mips_pkg::word_t      dec_opa, dec_opb;
    mips_pkg::creg_addr_t dec_dest;
    logic                 exe_fwd_valid, wr_en;
    mips_pkg::creg_addr_t exe_fwd_dest, wr_addr;
    mips_pkg::word_t      exe_fwd_data, wr_data;

    assign busy = dec_valid | wr_en;  // Something still on its way to the register file.

    wb_issue_port u_port (
        .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_rdata, .wb_ack,
        .busy, .rd_bus, .rd_addr(rd_addr_bus), .issue_valid, .issue_instr
    );

    decode_stage u_decode (
        .clk, .rst_n, .issue_valid, .issue_instr, .rd_a, .rd_b, .wr_en, .wr_addr, .wr_data,
        .exe_fwd_valid, .exe_fwd_dest, .exe_fwd_data, .rd_addr_a, .rd_addr_b,
        .dec_valid, .dec_func, .dec_opa, .dec_opb, .dec_dest, .dec_regwrite,
        .dec_movz, .dec_movn, .dec_trap_ovf, .dec_ri
    );

    execute_stage u_execute (
        .clk, .rst_n, .dec_valid, .dec_func, .dec_opa, .dec_opb, .dec_dest, .dec_regwrite,
        .dec_movz, .dec_movn, .dec_trap_ovf, .dec_ri, .exe_fwd_valid, .exe_fwd_dest,
        .exe_fwd_data, .wr_en, .wr_addr, .wr_data, .exc_count
    );

    reg_file u_reg_file (
        .clk, .rst_n, .wr_en, .wr_addr, .wr_data, .rd_addr_a, .rd_addr_b, .rd_addr_bus,
        .rd_a, .rd_b, .rd_bus
    );

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wr_en,
    input  mips_pkg::creg_addr_t wr_addr,
    input  mips_pkg::word_t      wr_data,
    input  mips_pkg::creg_addr_t rd_addr_a,
    input  mips_pkg::creg_addr_t rd_addr_b,
    input  mips_pkg::creg_addr_t rd_addr_bus,
    output mips_pkg::word_t      rd_a,
    output mips_pkg::word_t      rd_b,
    output mips_pkg::word_t      rd_bus
);
    mips_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;  // Register 0 stays zero.
        end
    end

    assign rd_a   = regs[rd_addr_a];
    assign rd_b   = regs[rd_addr_b];
    assign rd_bus = regs[rd_addr_bus];

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 dec_valid,
    input  mips_pkg::alu_func_t  dec_func,
    input  mips_pkg::word_t      dec_opa,
    input  mips_pkg::word_t      dec_opb,
    input  mips_pkg::creg_addr_t dec_dest,
    input  logic                 dec_regwrite,
    input  logic                 dec_movz,
    input  logic                 dec_movn,
    input  logic                 dec_trap_ovf,
    input  logic                 dec_ri,
    output logic                 exe_fwd_valid,
    output mips_pkg::creg_addr_t exe_fwd_dest,
    output mips_pkg::word_t      exe_fwd_data,
    output logic                 wr_en,
    output mips_pkg::creg_addr_t wr_addr,
    output mips_pkg::word_t      wr_data,
    output logic [7:0]           exc_count
);
    mips_pkg::word_t alu_out;
    mips_pkg::word_t sum;
    mips_pkg::word_t diff;
    logic add_ovf;
    logic sub_ovf;
    logic ovf;
    logic cond_ok;
    logic do_write;

    assign sum  = dec_opa + dec_opb;
    assign diff = dec_opa - dec_opb;

    // Signed overflow when the result sign disagrees with what the operands allow.
    assign add_ovf = (dec_opa[31] == dec_opb[31]) && (sum[31] != dec_opa[31]);
    assign sub_ovf = (dec_opa[31] != dec_opb[31]) && (diff[31] != dec_opa[31]);
    assign ovf = dec_trap_ovf && ((dec_func == mips_pkg::ALU_SUB) ? sub_ovf : add_ovf);

    always_comb begin
        case (dec_func)
            mips_pkg::ALU_ADD:   alu_out = sum;
            mips_pkg::ALU_SUB:   alu_out = diff;
            mips_pkg::ALU_SLT:   alu_out = {31'd0, $signed(dec_opa) < $signed(dec_opb)};
            mips_pkg::ALU_SLTU:  alu_out = {31'd0, dec_opa < dec_opb};
            mips_pkg::ALU_AND:   alu_out = dec_opa & dec_opb;
            mips_pkg::ALU_OR:    alu_out = dec_opa | dec_opb;
            mips_pkg::ALU_XOR:   alu_out = dec_opa ^ dec_opb;
            mips_pkg::ALU_NOR:   alu_out = ~(dec_opa | dec_opb);
            mips_pkg::ALU_SLL:   alu_out = dec_opa << dec_opb[4:0];
            mips_pkg::ALU_SRL:   alu_out = dec_opa >> dec_opb[4:0];
            mips_pkg::ALU_SRA:   alu_out = $signed(dec_opa) >>> dec_opb[4:0];
            mips_pkg::ALU_LUI:   alu_out = {dec_opb[15:0], 16'h0000};
            mips_pkg::ALU_PASSA: alu_out = dec_opa;
            default:             alu_out = '0;
        endcase
    end

    // MOVZ and MOVN test rt, which travels as operand B.
    assign cond_ok = !(dec_movz && dec_opb != '0) && !(dec_movn && dec_opb == '0) && !ovf;
    assign do_write = dec_valid && dec_regwrite && cond_ok && (dec_dest != '0);

    assign exe_fwd_valid = do_write;
    assign exe_fwd_dest  = dec_dest;
    assign exe_fwd_data  = alu_out;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_en     <= 1'b0;
            exc_count <= 8'd0;
        end else begin
            wr_en <= do_write;
            if (dec_valid && (dec_ri || ovf)) begin
                exc_count <= exc_count + 8'd1;  // Wraps after 255.
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_addr <= dec_dest;
        wr_data <= alu_out;
    end

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue_valid,
    input  mips_pkg::word_t      issue_instr,
    input  mips_pkg::word_t      rd_a,
    input  mips_pkg::word_t      rd_b,
    input  logic                 wr_en,
    input  mips_pkg::creg_addr_t wr_addr,
    input  mips_pkg::word_t      wr_data,
    input  logic                 exe_fwd_valid,
    input  mips_pkg::creg_addr_t exe_fwd_dest,
    input  mips_pkg::word_t      exe_fwd_data,
    output mips_pkg::creg_addr_t rd_addr_a,
    output mips_pkg::creg_addr_t rd_addr_b,
    output logic                 dec_valid,
    output mips_pkg::alu_func_t  dec_func,
    output mips_pkg::word_t      dec_opa,
    output mips_pkg::word_t      dec_opb,
    output mips_pkg::creg_addr_t dec_dest,
    output logic                 dec_regwrite,
    output logic                 dec_movz,
    output logic                 dec_movn,
    output logic                 dec_trap_ovf,
    output logic                 dec_ri
);
    mips_pkg::alu_func_t  alu_func;
    mips_pkg::creg_addr_t destreg;
    mips_pkg::word_t      opa;
    mips_pkg::word_t      reg_b;
    mips_pkg::word_t      imm_ext;
    logic use_imm, zero_ext, use_shamt, regwrite;
    logic is_movz, is_movn, trap_ovf, exception_ri;

    main_decode u_main_decode (
        .instr        (issue_instr),
        .alu_func     (alu_func),
        .use_imm      (use_imm),
        .zero_ext     (zero_ext),
        .use_shamt    (use_shamt),
        .regwrite     (regwrite),
        .is_movz      (is_movz),
        .is_movn      (is_movn),
        .trap_ovf     (trap_ovf),
        .exception_ri (exception_ri),
        .srcrega      (rd_addr_a),
        .srcregb      (rd_addr_b),
        .destreg      (destreg)
    );

    // Youngest producer wins; register 0 never appears as a valid destination.
    always_comb begin
        if (exe_fwd_valid && exe_fwd_dest == rd_addr_a) opa = exe_fwd_data;
        else if (wr_en && wr_addr == rd_addr_a)          opa = wr_data;
        else                                             opa = rd_a;
        if (exe_fwd_valid && exe_fwd_dest == rd_addr_b) reg_b = exe_fwd_data;
        else if (wr_en && wr_addr == rd_addr_b)          reg_b = wr_data;
        else                                             reg_b = rd_b;
    end

    assign imm_ext = zero_ext ? {16'h0000, issue_instr[15:0]} :
                                {{16{issue_instr[15]}}, issue_instr[15:0]};

    always_ff @(posedge clk) begin
        if (!rst_n) dec_valid <= 1'b0;
        else        dec_valid <= issue_valid;
    end

    always_ff @(posedge clk) begin
        dec_func     <= alu_func;
        dec_opa      <= opa;
        dec_opb      <= use_shamt ? {27'd0, issue_instr[10:6]} : (use_imm ? imm_ext : reg_b);
        dec_dest     <= destreg;
        dec_regwrite <= regwrite;
        dec_movz     <= is_movz;
        dec_movn     <= is_movn;
        dec_trap_ovf <= trap_ovf;
        dec_ri       <= exception_ri;
    end

endmodule

// ==== hdl/main_decode.sv ====
`timescale 1ns/1ps

module main_decode (
    input  mips_pkg::word_t      instr,
    output mips_pkg::alu_func_t  alu_func,
    output logic                 use_imm,
    output logic                 zero_ext,
    output logic                 use_shamt,
    output logic                 regwrite,
    output logic                 is_movz,
    output logic                 is_movn,
    output logic                 trap_ovf,
    output logic                 exception_ri,
    output mips_pkg::creg_addr_t srcrega,
    output mips_pkg::creg_addr_t srcregb,
    output mips_pkg::creg_addr_t destreg
);
    mips_pkg::op_t        op;
    mips_pkg::func_t      func;
    mips_pkg::creg_addr_t rs;
    mips_pkg::creg_addr_t rt;
    mips_pkg::creg_addr_t rd;

    assign op   = instr[31:26];
    assign func = instr[5:0];
    assign rs   = instr[25:21];
    assign rt   = instr[20:16];
    assign rd   = instr[15:11];

    always_comb begin
        alu_func     = mips_pkg::ALU_ADD;
        use_imm      = 1'b0;
        zero_ext     = 1'b0;
        use_shamt    = 1'b0;
        regwrite     = 1'b0;
        is_movz      = 1'b0;
        is_movn      = 1'b0;
        trap_ovf     = 1'b0;
        exception_ri = 1'b0;
        srcrega      = '0;
        srcregb      = '0;
        destreg      = '0;
        case (op)
            mips_pkg::OP_RT: begin
                regwrite = 1'b1;
                srcrega  = rs;
                srcregb  = rt;
                destreg  = rd;
                case (func)
                    mips_pkg::F_ADD: begin
                        alu_func = mips_pkg::ALU_ADD;
                        trap_ovf = 1'b1;
                    end
                    mips_pkg::F_ADDU: alu_func = mips_pkg::ALU_ADD;
                    mips_pkg::F_SUB: begin
                        alu_func = mips_pkg::ALU_SUB;
                        trap_ovf = 1'b1;
                    end
                    mips_pkg::F_SUBU: alu_func = mips_pkg::ALU_SUB;
                    mips_pkg::F_SLT:  alu_func = mips_pkg::ALU_SLT;
                    mips_pkg::F_SLTU: alu_func = mips_pkg::ALU_SLTU;
                    mips_pkg::F_AND:  alu_func = mips_pkg::ALU_AND;
                    mips_pkg::F_OR:   alu_func = mips_pkg::ALU_OR;
                    mips_pkg::F_XOR:  alu_func = mips_pkg::ALU_XOR;
                    mips_pkg::F_NOR:  alu_func = mips_pkg::ALU_NOR;
                    mips_pkg::F_SLL, mips_pkg::F_SRL, mips_pkg::F_SRA: begin
                        use_shamt = 1'b1;  // Value in rt, amount from the instruction.
                        srcrega   = rt;
                        srcregb   = '0;
                        alu_func  = (func == mips_pkg::F_SLL) ? mips_pkg::ALU_SLL :
                                    (func == mips_pkg::F_SRL) ? mips_pkg::ALU_SRL :
                                                                mips_pkg::ALU_SRA;
                    end
                    mips_pkg::F_SLLV, mips_pkg::F_SRLV, mips_pkg::F_SRAV: begin
                        srcrega  = rt;  // Value in rt, amount in rs.
                        srcregb  = rs;
                        alu_func = (func == mips_pkg::F_SLLV) ? mips_pkg::ALU_SLL :
                                   (func == mips_pkg::F_SRLV) ? mips_pkg::ALU_SRL :
                                                                mips_pkg::ALU_SRA;
                    end
                    mips_pkg::F_MOVZ: begin
                        alu_func = mips_pkg::ALU_PASSA;
                        is_movz  = 1'b1;
                    end
                    mips_pkg::F_MOVN: begin
                        alu_func = mips_pkg::ALU_PASSA;
                        is_movn  = 1'b1;
                    end
                    mips_pkg::F_SYNC: begin
                        regwrite = 1'b0;
                        srcrega  = '0;
                        srcregb  = '0;
                        destreg  = '0;
                    end
                    default: begin
                        exception_ri = 1'b1;
                        regwrite     = 1'b0;
                        srcrega      = '0;
                        srcregb      = '0;
                        destreg      = '0;
                    end
                endcase
            end
            mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU,
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
                use_imm  = 1'b1;
                regwrite = 1'b1;
                srcrega  = (op == mips_pkg::OP_LUI) ? '0 : rs;
                destreg  = rt;
                case (op)
                    mips_pkg::OP_ADDI: begin
                        alu_func = mips_pkg::ALU_ADD;
                        trap_ovf = 1'b1;
                    end
                    mips_pkg::OP_ADDIU: alu_func = mips_pkg::ALU_ADD;
                    mips_pkg::OP_SLTI:  alu_func = mips_pkg::ALU_SLT;
                    mips_pkg::OP_SLTIU: alu_func = mips_pkg::ALU_SLTU;
                    mips_pkg::OP_ANDI: begin
                        alu_func = mips_pkg::ALU_AND;
                        zero_ext = 1'b1;
                    end
                    mips_pkg::OP_ORI: begin
                        alu_func = mips_pkg::ALU_OR;
                        zero_ext = 1'b1;
                    end
                    mips_pkg::OP_XORI: begin
                        alu_func = mips_pkg::ALU_XOR;
                        zero_ext = 1'b1;
                    end
                    default: alu_func = mips_pkg::ALU_LUI;
                endcase
            end
            default: exception_ri = 1'b1;
        endcase
    end

endmodule

// ==== hdl/wb_issue_port.sv ====
`timescale 1ns/1ps

module wb_issue_port (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  mips_pkg::creg_addr_t wb_adr,
    input  mips_pkg::word_t      wb_wdata,
    output mips_pkg::word_t      wb_rdata,
    output logic                 wb_ack,
    input  logic                 busy,
    input  mips_pkg::word_t      rd_bus,
    output mips_pkg::creg_addr_t rd_addr,
    output logic                 issue_valid,
    output mips_pkg::word_t      issue_instr
);
    logic acked;  // Current strobe already answered.
    logic req;

    assign rd_addr = wb_adr;
    assign req = wb_cyc && wb_stb && !acked;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack      <= 1'b0;
            issue_valid <= 1'b0;
            acked       <= 1'b0;
        end else begin
            wb_ack      <= 1'b0;
            issue_valid <= 1'b0;
            if (!wb_stb) begin
                acked <= 1'b0;
            end else if (req && wb_we) begin
                wb_ack      <= 1'b1;
                issue_valid <= 1'b1;
                acked       <= 1'b1;
            end else if (req && !busy) begin
                wb_ack <= 1'b1;  // The pipeline has drained so the register file is current.
                acked  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && wb_we) begin
            issue_instr <= wb_wdata;
        end
        if (req && !wb_we && !busy) begin
            wb_rdata <= rd_bus;
        end
    end

endmodule

// ==== hdl/mips_pkg.sv ====
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  creg_addr_t;
    typedef logic [5:0]  op_t;
    typedef logic [5:0]  func_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_PASSA  // Result is operand A, used by MOVZ and MOVN.
    } alu_func_t;

    localparam op_t OP_RT    = 6'h00;
    localparam op_t OP_ADDI  = 6'h08;
    localparam op_t OP_ADDIU = 6'h09;
    localparam op_t OP_SLTI  = 6'h0a;
    localparam op_t OP_SLTIU = 6'h0b;
    localparam op_t OP_ANDI  = 6'h0c;
    localparam op_t OP_ORI   = 6'h0d;
    localparam op_t OP_XORI  = 6'h0e;
    localparam op_t OP_LUI   = 6'h0f;

    localparam func_t F_SLL  = 6'h00;
    localparam func_t F_SRL  = 6'h02;
    localparam func_t F_SRA  = 6'h03;
    localparam func_t F_SLLV = 6'h04;
    localparam func_t F_SRLV = 6'h06;
    localparam func_t F_SRAV = 6'h07;
    localparam func_t F_MOVZ = 6'h0a;
    localparam func_t F_MOVN = 6'h0b;
    localparam func_t F_SYNC = 6'h0f;
    localparam func_t F_ADD  = 6'h20;
    localparam func_t F_ADDU = 6'h21;
    localparam func_t F_SUB  = 6'h22;
    localparam func_t F_SUBU = 6'h23;
    localparam func_t F_AND  = 6'h24;
    localparam func_t F_OR   = 6'h25;
    localparam func_t F_XOR  = 6'h26;
    localparam func_t F_NOR  = 6'h27;
    localparam func_t F_SLT  = 6'h2a;
    localparam func_t F_SLTU = 6'h2b;

endpackage
